// ==== common/mem_pkg.sv ====
/*
 * memory path shared definitions
 * register offsets, reset values and AXI response codes for the
 * configuration block, plus the control register word layout
 */
`default_nettype none

package mem_pkg;

	// register map, byte offsets on the AXI side
	localparam logic [11:0] ctrl_offset  = 12'h000;
	localparam logic [11:0] count_offset = 12'h004;

	// overlay on at power up so the boot code shows at 0
	// mirror off, one chip block present
	localparam logic [31:0] ctrl_reset = 32'h0000_0008;

	// AXI response codes
	localparam logic [1:0] resp_okay   = 2'b00;
	localparam logic [1:0] resp_slverr = 2'b10;

	// control register
	// raw view is what the AXI side writes under byte strobes,
	// field view is what the bank decoder looks at
	typedef union packed {
		logic [31:0] raw;
		struct packed {
			// unused, kept writable
			logic [27:0] reserved;
			// boot overlay of kickstart at chip block 0
			logic        ovl;
			// kickstart mirror at F8xxxx
			logic        mirror_en;
			// chip blocks present, minus one
			logic [1:0]  chipram_size;
		} f;
	} mem_ctrl_u;

endpackage

`default_nettype wire

// ==== hdl/bank_decoder.sv ====
/*
 * bank decoder
 * sorts a 68000 word address into one of the eight memory bank
 * selects, using overlay, mirror and chip RAM size from the
 * control register
 */
`default_nettype none

module bank_decoder (
	// bus word address
	input  logic [23:1]       address_in,
	// control register, field view used here
	input  mem_pkg::mem_ctrl_u cfg_word,
	// one hot bank selects, bit 5 goes along with a chip block
	output logic [7:0]        bank
);

	// region hits
	logic       kick_region;
	logic       chip_region;
	logic       slow_region;
	// chip block number within the 2 MB chip space
	logic [1:0] blk;
	// kickstart mirror takes the lower half of F8-FF
	logic       mirror_hit;

	// F8xxxx to FFxxxx
	assign kick_region = &address_in[23:19];
	// 000000 to 1FFFFF
	assign chip_region = (address_in[23:21] == 3'b000);
	// C00000 to C7FFFF
	assign slow_region = (address_in[23:19] == 5'b11000);

	assign blk = address_in[20:19];

	// only with overlay off, and only F8-FB
	assign mirror_hit = cfg_word.f.mirror_en && !cfg_word.f.ovl && !address_in[18];

	always_comb begin
		bank = 8'h00;
		if (kick_region) begin
			// mirror or plain kickstart
			if (mirror_hit)
				bank[6] = 1'b1;
			else
				bank[7] = 1'b1;
		end else if (chip_region) begin
			if (cfg_word.f.ovl && blk == 2'd0) begin
				// boot overlay hides chip block 0
				bank[7] = 1'b1;
			end else if (blk <= cfg_word.f.chipram_size) begin
				// present chip block plus shared chip flag
				bank[blk] = 1'b1;
				bank[5]   = 1'b1;
			end
			// blocks above chipram_size stay unselected
		end else if (slow_region) begin
			bank[4] = 1'b1;
		end
		// anything else is unmapped
	end

endmodule

`default_nettype wire

// ==== sram_bridge/sram_bridge.sv ====
/*
 * SRAM bridge
 * combinational strobes for an asynchronous 16-bit SRAM, remap of
 * the upper address bits into physical SRAM space and read data mux
 */
`default_nettype none

module sram_bridge (
	// bank selects from the decoder
	input  logic [7:0]  bank,
	// bus side
	input  logic [23:1] address_in,
	input  logic [15:0] data_in,
	output logic [15:0] data_out,
	input  logic        rd,
	input  logic        hwr,
	input  logic        lwr,
	// SRAM side, strobes active low
	output logic        _bhe,
	output logic        _ble,
	output logic        _we,
	output logic        _oe,
	output logic [22:1] address,
	output logic [15:0] data,
	input  logic [15:0] ramdata_in,
	// completed access, to the counter
	output logic        access
);

	// any bank selected means a memory cycle
	logic enable;

	assign enable = |bank;

	// write strobe when either byte lane writes
	assign _we = !(enable && (hwr || lwr));

	// output enable for reads
	assign _oe = !(enable && rd);

	// byte lanes
	assign _bhe = !(enable && hwr);
	assign _ble = !(enable && lwr);

	// low bits go straight through
	assign address[17:1] = address_in[17:1];

	// upper bits, first match wins
	always_comb begin
		if (bank[6]) begin
			// mirror, F8-FB maps onto FC-FF
			address[22:18] = 5'b11111;
		end else if (bank[7]) begin
			// kickstart, also boot overlay
			address[22:18] = {4'b1111, address_in[18]};
		end else if (bank[5]) begin
			// chip block number from the one hot selects
			address[22:18] = {2'b00, bank[3] | bank[2], bank[3] | bank[1],
				address_in[18]};
		end else begin
			// slow RAM and the rest pass through
			address[22:18] = address_in[22:18];
		end
	end

	// zero when not reading from SRAM
	assign data_out = (enable && rd) ? ramdata_in : 16'h0000;

	// separate write data port, no tri-state
	assign data = data_in;

	// counted once per cycle with a selected bank and a strobe
	assign access = enable && (rd || hwr || lwr);

endmodule

`default_nettype wire

// ==== sram_bridge/bridge_config_regs.sv ====
/*
 * bridge configuration registers
 * AXI4-Lite slave with the control word (overlay, mirror, chip RAM
 * size) and a 32-bit counter of completed memory accesses
 */
`default_nettype none

module bridge_config_regs (
	input  logic               clk,
	input  logic               reset,
	// write address
	input  logic [11:0]        awaddr,
	input  logic               awvalid,
	output logic               awready,
	// write data
	input  logic [31:0]        wdata,
	input  logic [3:0]         wstrb,
	input  logic               wvalid,
	output logic               wready,
	// write response
	output logic [1:0]         bresp,
	output logic               bvalid,
	input  logic               bready,
	// read address
	input  logic [11:0]        araddr,
	input  logic               arvalid,
	output logic               arready,
	// read data
	output logic [31:0]        rdata,
	output logic [1:0]         rresp,
	output logic               rvalid,
	input  logic               rready,
	// memory access strobe from the bridge
	input  logic               access,
	// control word to the decoder
	output mem_pkg::mem_ctrl_u cfg_word
);

	mem_pkg::mem_ctrl_u ctrl;
	logic [31:0]        count;
	// handshake edges
	logic               wr_fire;
	logic               rd_fire;
	// write offset decode
	logic               wr_ctrl;
	logic               wr_count;

	assign wr_fire  = awready && awvalid && wready && wvalid;
	assign rd_fire  = arready && arvalid;
	assign wr_ctrl  = wr_fire && (awaddr == mem_pkg::ctrl_offset);
	assign wr_count = wr_fire && (awaddr == mem_pkg::count_offset);

	// write channel
	// accept address and data together then hold bvalid until bready
	always_ff @(posedge clk) begin
		if (reset) begin
			awready <= 1'b0;
			wready  <= 1'b0;
			bvalid  <= 1'b0;
		end else begin
			// one cycle ready pulse unless a response is pending
			awready <= !awready && !bvalid && awvalid && wvalid;
			wready  <= !awready && !bvalid && awvalid && wvalid;
			if (wr_fire)
				bvalid <= 1'b1;
			else if (bready)
				bvalid <= 1'b0;
		end
	end

	// response code for the accepted offset
	always_ff @(posedge clk) begin
		if (wr_fire)
			bresp <= (wr_ctrl || wr_count) ? mem_pkg::resp_okay
				: mem_pkg::resp_slverr;
	end

	// control word written per byte lane
	always_ff @(posedge clk) begin
		if (reset) begin
			ctrl.raw <= mem_pkg::ctrl_reset;
		end else if (wr_ctrl) begin
			for (int i = 0; i < 4; i++) begin
				if (wstrb[i])
					ctrl.raw[8*i +: 8] <= wdata[8*i +: 8];
			end
		end
	end

	// access counter cleared by a write of any value
	always_ff @(posedge clk) begin
		if (reset)
			count <= 32'h0;
		else if (wr_count)
			count <= 32'h0;
		else if (access)
			count <= count + 32'd1;
	end

	// read channel
	always_ff @(posedge clk) begin
		if (reset) begin
			arready <= 1'b0;
			rvalid  <= 1'b0;
		end else begin
			arready <= !arready && !rvalid && arvalid;
			if (rd_fire)
				rvalid <= 1'b1;
			else if (rready)
				rvalid <= 1'b0;
		end
	end

	// read data captured at the address handshake and held while rvalid
	always_ff @(posedge clk) begin
		if (rd_fire) begin
			if (araddr == mem_pkg::ctrl_offset) begin
				rdata <= ctrl.raw;
				rresp <= mem_pkg::resp_okay;
			end else if (araddr == mem_pkg::count_offset) begin
				rdata <= count;
				rresp <= mem_pkg::resp_okay;
			end else begin
				// unmapped offset
				rdata <= 32'h0;
				rresp <= mem_pkg::resp_slverr;
			end
		end
	end

	assign cfg_word = ctrl;

endmodule

`default_nettype wire

// ==== hdl/chipset_memory.sv ====
/*
 * chipset memory path top
 * bank decoder, SRAM bridge and AXI4-Lite configuration block
 */
`default_nettype none

module chipset_memory (
	input  logic        clk,
	input  logic        reset,
	// AXI4-Lite configuration port
	input  logic [11:0] awaddr,
	input  logic        awvalid,
	output logic        awready,
	input  logic [31:0] wdata,
	input  logic [3:0]  wstrb,
	input  logic        wvalid,
	output logic        wready,
	output logic [1:0]  bresp,
	output logic        bvalid,
	input  logic        bready,
	input  logic [11:0] araddr,
	input  logic        arvalid,
	output logic        arready,
	output logic [31:0] rdata,
	output logic [1:0]  rresp,
	output logic        rvalid,
	input  logic        rready,
	// bus master side
	input  logic [23:1] address_in,
	input  logic [15:0] data_in,
	output logic [15:0] data_out,
	input  logic        rd,
	input  logic        hwr,
	input  logic        lwr,
	// SRAM side
	output logic        _bhe,
	output logic        _ble,
	output logic        _we,
	output logic        _oe,
	output logic [22:1] address,
	output logic [15:0] data,
	input  logic [15:0] ramdata_in
);

	// decoder to bridge
	logic [7:0]         bank;
	// configuration to decoder
	mem_pkg::mem_ctrl_u cfg_word;
	// bridge to counter
	logic               access;

	bank_decoder u_bank_decoder (
		.address_in (address_in),
		.cfg_word   (cfg_word),
		.bank       (bank)
	);

	sram_bridge u_sram_bridge (
		.bank       (bank),
		.address_in (address_in),
		.data_in    (data_in),
		.data_out   (data_out),
		.rd         (rd),
		.hwr        (hwr),
		.lwr        (lwr),
		._bhe       (_bhe),
		._ble       (_ble),
		._we        (_we),
		._oe        (_oe),
		.address    (address),
		.data       (data),
		.ramdata_in (ramdata_in),
		.access     (access)
	);

	bridge_config_regs u_bridge_config_regs (
		.clk      (clk),
		.reset    (reset),
		.awaddr   (awaddr),
		.awvalid  (awvalid),
		.awready  (awready),
		.wdata    (wdata),
		.wstrb    (wstrb),
		.wvalid   (wvalid),
		.wready   (wready),
		.bresp    (bresp),
		.bvalid   (bvalid),
		.bready   (bready),
		.araddr   (araddr),
		.arvalid  (arvalid),
		.arready  (arready),
		.rdata    (rdata),
		.rresp    (rresp),
		.rvalid   (rvalid),
		.rready   (rready),
		.access   (access),
		.cfg_word (cfg_word)
	);

endmodule

`default_nettype wire

// ==== tb/chipset_memory_assertions.sv ====
/*
 * memory path checker
 * SRAM strobe consistency and AXI response hold
 * bound into the memory path top
 */
`default_nettype none

module chipset_memory_assertions (
	input logic clk,
	input logic reset,
	input logic _we,
	input logic _oe,
	input logic rd,
	input logic hwr,
	input logic lwr,
	input logic bvalid,
	input logic bready,
	input logic rvalid,
	input logic rready
);
	timeunit 1ns;
	timeprecision 1ps;

	// number of failed assertions so far
	int fails;

	// write and output enable together only on a read with a byte write
	strobe_overlap: assert property (@(posedge clk) disable iff (reset)
		(!_we && !_oe) |-> (rd && (hwr || lwr)))
		else begin
			$error("_we and _oe low together without rd and a byte write");
			fails++;
		end

	// write response waits for bready
	bvalid_hold: assert property (@(posedge clk) disable iff (reset)
		(bvalid && !bready) |=> bvalid)
		else begin
			$error("bvalid dropped before bready");
			fails++;
		end

	// read data waits for rready
	rvalid_hold: assert property (@(posedge clk) disable iff (reset)
		(rvalid && !rready) |=> rvalid)
		else begin
			$error("rvalid dropped before rready");
			fails++;
		end

endmodule

bind chipset_memory chipset_memory_assertions u_assertions (
	.clk    (clk),
	.reset  (reset),
	._we    (_we),
	._oe    (_oe),
	.rd     (rd),
	.hwr    (hwr),
	.lwr    (lwr),
	.bvalid (bvalid),
	.bready (bready),
	.rvalid (rvalid),
	.rready (rready)
);

`default_nettype wire

// ==== tb/chipset_memory_tb.sv ====
/*
 * memory path testbench
 * random bus traffic and AXI4-Lite configuration checked against
 * a model of bank decoding, SRAM remap, strobes and access count
 */
`default_nettype none

module chipset_memory_tb;
	timeunit 1ns;
	timeprecision 1ps;

	// run length with two cycles per bus op
	localparam int rounds = 4;
	localparam int ops_per_round = 64;
	localparam int bus_cycles = 2 * (rounds * ops_per_round + 8);
	localparam int axi_cycles = 30 * 10;
	localparam int cycle_limit = 4 * (8 + bus_cycles + axi_cycles);

	logic        clk;
	logic        reset;
	logic [11:0] awaddr;
	logic        awvalid;
	logic        awready;
	logic [31:0] wdata;
	logic [3:0]  wstrb;
	logic        wvalid;
	logic        wready;
	logic [1:0]  bresp;
	logic        bvalid;
	logic        bready;
	logic [11:0] araddr;
	logic        arvalid;
	logic        arready;
	logic [31:0] rdata;
	logic [1:0]  rresp;
	logic        rvalid;
	logic        rready;
	logic [23:1] address_in;
	logic [15:0] data_in;
	logic [15:0] data_out;
	logic        rd;
	logic        hwr;
	logic        lwr;
	logic        _bhe;
	logic        _ble;
	logic        _we;
	logic        _oe;
	logic [22:1] address;
	logic [15:0] data;
	logic [15:0] ramdata_in;

	// SRAM model over the full 4M word space
	logic [15:0]        sram [0:(1 << 22) - 1];
	// expected contents of every word written so far
	logic [15:0]        ref_mem [logic [22:1]];
	mem_pkg::mem_ctrl_u cfg_model;
	logic [31:0]        count_model;
	int                 errors;
	int                 checks;
	int                 cycles;
	string              test_name;

	chipset_memory UUT (.*);

	always #5 clk = ~clk;

	// asynchronous read
	assign ramdata_in = sram[address];

	// byte writes while _we is low
	always @(posedge clk) begin
		if (!_we) begin
			if (!_bhe)
				sram[address][15:8] <= data[15:8];
			if (!_ble)
				sram[address][7:0] <= data[7:0];
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= cycle_limit) begin
			$display("timeout: run did not end within %0d cycles", cycle_limit);
			$display("checks: %0d, errors: %0d, assertion failures: %0d", checks, errors,
				UUT.u_assertions.fails);
			$display("Errors found");
			$finish;
		end
	end

	// power-up contents mixing all address bits
	function automatic logic [15:0] fill(input logic [22:1] a);
		return a[16:1] ^ {a[22:17], 10'h000} ^ 16'h5a3c;
	endfunction

	// expected SRAM address plus whether any bank is hit
	function automatic logic map_addr(input logic [23:1] a, output logic [22:1] sa);
		logic hit;
		hit = 1'b1;
		sa = a[22:1];
		if (a[23:19] == 5'b11111) begin
			// mirror folds F8-FB onto FC-FF
			if (cfg_model.f.mirror_en && !cfg_model.f.ovl)
				sa[22:18] = 5'b11111;
			else
				sa[22:18] = {4'b1111, a[18]};
		end else if (a[23:21] == 3'b000) begin
			// overlay shows kickstart in block 0
			if (cfg_model.f.ovl && a[20:19] == 2'd0)
				sa[22:18] = {4'b1111, a[18]};
			else if (a[20:19] <= cfg_model.f.chipram_size)
				sa[22:18] = {2'b00, a[20:19], a[18]};
			else
				hit = 1'b0;
		end else if (a[23:19] != 5'b11000) begin
			// not slow RAM either
			hit = 1'b0;
		end
		return hit;
	endfunction

	// region mix with a small offset range so writes and reads meet
	function automatic logic [23:0] rand_addr();
		logic [23:0] a;
		a = {5'h00, 1'($urandom), 13'h0000, 4'($urandom), 1'b0};
		case ($urandom_range(4))
			0: a[23:19] = {3'b000, 2'($urandom)};
			1: a[23:19] = 5'b11000;
			2: a[23:19] = 5'b11111;
			default: a[23:19] = 5'($urandom);
		endcase
		return a;
	endfunction

	task automatic check_word(input string what, input logic [15:0] exp, input logic [15:0] act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("ERROR %s %s: expected %h, actual %h", test_name, what, exp, act);
		end
	endtask

	task automatic check_addr(input string what, input logic [22:1] exp, input logic [22:1] act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("ERROR %s %s: expected %h, actual %h", test_name, what, exp, act);
		end
	endtask

	task automatic check_strobes(input string what, input logic [3:0] exp, input logic [3:0] act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("ERROR %s %s: expected %b, actual %b", test_name, what, exp, act);
		end
	endtask

	task automatic check_reg(input string what, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("ERROR %s %s: expected %h, actual %h", test_name, what, exp, act);
		end
	endtask

	task automatic check_resp(input string what, input logic [1:0] exp, input logic [1:0] act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("ERROR %s %s: expected %b, actual %b", test_name, what, exp, act);
		end
	endtask

	// one bus cycle checked mid-cycle before going back to idle
	task automatic bus_op(input logic [23:0] ba, input logic r, input logic [1:0] lanes,
		input logic [15:0] wd);
		logic [22:1] sa;
		logic        hit;
		logic [15:0] word;
		hit = map_addr(ba[23:1], sa);
		word = ref_mem.exists(sa) ? ref_mem[sa] : fill(sa);
		@(posedge clk);
		address_in <= ba[23:1];
		data_in <= wd;
		rd <= r;
		hwr <= lanes[1];
		lwr <= lanes[0];
		@(negedge clk);
		check_addr("sram address", sa, address);
		check_strobes("strobes", hit ? {~lanes[1], ~lanes[0], ~|lanes, ~r} : 4'hf,
			{_bhe, _ble, _we, _oe});
		check_word("read data", (hit && r) ? word : 16'h0000, data_out);
		check_word("write data", wd, data);
		if (hit && (r || |lanes))
			count_model++;
		// merged bytes land on the next edge
		if (lanes[1])
			word[15:8] = wd[15:8];
		if (lanes[0])
			word[7:0] = wd[7:0];
		if (hit && |lanes)
			ref_mem[sa] = word;
		@(posedge clk);
		rd <= 1'b0;
		hwr <= 1'b0;
		lwr <= 1'b0;
	endtask

	task automatic axi_write(input logic [11:0] addr, input logic [31:0] wd,
		input logic [3:0] strb, input logic [1:0] exp_resp);
		int gap;
		gap = $urandom_range(3);
		@(posedge clk);
		awaddr <= addr;
		awvalid <= 1'b1;
		wdata <= wd;
		wstrb <= strb;
		wvalid <= 1'b1;
		do @(negedge clk); while (!awready);
		if (!wready) begin
			errors++;
			$display("wready did not rise together with awready at offset %h", addr);
		end
		@(posedge clk);
		awvalid <= 1'b0;
		wvalid <= 1'b0;
		// random response back-pressure
		repeat (gap) @(posedge clk);
		bready <= 1'b1;
		@(negedge clk);
		if (!bvalid) begin
			errors++;
			$display("no write response for offset %h", addr);
		end
		check_resp("bresp", exp_resp, bresp);
		@(posedge clk);
		bready <= 1'b0;
		if (addr == mem_pkg::ctrl_offset) begin
			for (int i = 0; i < 4; i++) begin
				if (strb[i])
					cfg_model.raw[8*i +: 8] = wd[8*i +: 8];
			end
		end else if (addr == mem_pkg::count_offset) begin
			count_model = 32'h0;
		end
	endtask

	task automatic axi_read(input logic [11:0] addr, input logic [31:0] exp_data,
		input logic [1:0] exp_resp);
		int gap;
		gap = $urandom_range(3);
		@(posedge clk);
		araddr <= addr;
		arvalid <= 1'b1;
		do @(negedge clk); while (!arready);
		@(posedge clk);
		arvalid <= 1'b0;
		repeat (gap) @(posedge clk);
		rready <= 1'b1;
		@(negedge clk);
		if (!rvalid) begin
			errors++;
			$display("no read data for offset %h", addr);
		end
		check_reg("rdata", exp_data, rdata);
		check_resp("rresp", exp_resp, rresp);
		@(posedge clk);
		rready <= 1'b0;
	endtask

	initial begin
		void'($urandom(32'hefb52b7e));
		clk = 1'b0;
		reset = 1'b1;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wstrb = '0;
		wvalid = 1'b0;
		bready = 1'b0;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		address_in = '0;
		data_in = '0;
		rd = 1'b0;
		hwr = 1'b0;
		lwr = 1'b0;
		errors = 0;
		checks = 0;
		cycles = 0;
		count_model = 32'h0;
		// overlay on, mirror off, one chip block
		cfg_model.raw = 32'h0;
		cfg_model.f.ovl = 1'b1;
		for (int i = 0; i < (1 << 22); i++)
			sram[i] = fill(i[21:0]);
		repeat (8) @(posedge clk);
		reset <= 1'b0;

		test_name = "reset";
		axi_read(mem_pkg::ctrl_offset, cfg_model.raw, mem_pkg::resp_okay);
		axi_read(mem_pkg::count_offset, 32'h0, mem_pkg::resp_okay);

		// kickstart seen at 0 until overlay drops
		test_name = "overlay";
		bus_op(24'hf80010, 1'b0, 2'b11, 16'hbeef);
		bus_op(24'h000010, 1'b1, 2'b00, 16'h0000);
		axi_write(mem_pkg::ctrl_offset, 32'h0, 4'hf, mem_pkg::resp_okay);
		bus_op(24'h000010, 1'b1, 2'b00, 16'h0000);

		test_name = "mirror";
		axi_write(mem_pkg::ctrl_offset, 32'h4, 4'h1, mem_pkg::resp_okay);
		bus_op(24'hf80020, 1'b0, 2'b11, 16'h1234);
		bus_op(24'hfc0020, 1'b1, 2'b00, 16'h0000);
		axi_write(mem_pkg::ctrl_offset, 32'h0, 4'h1, mem_pkg::resp_okay);
		bus_op(24'hf80030, 1'b0, 2'b11, 16'h5678);
		bus_op(24'hfc0030, 1'b1, 2'b00, 16'h0000);
		// chip block 2 absent with one block
		bus_op(24'h100000, 1'b1, 2'b01, 16'h9abc);
		axi_read(mem_pkg::count_offset, count_model, mem_pkg::resp_okay);

		for (int r = 0; r < rounds; r++) begin
			test_name = $sformatf("random %0d", r);
			axi_write(mem_pkg::ctrl_offset, $urandom, 4'($urandom), mem_pkg::resp_okay);
			axi_read(mem_pkg::ctrl_offset, cfg_model.raw, mem_pkg::resp_okay);
			for (int i = 0; i < ops_per_round; i++)
				bus_op(rand_addr(), 1'($urandom), 2'($urandom), 16'($urandom));
			axi_read(mem_pkg::count_offset, count_model, mem_pkg::resp_okay);
			// any value clears the counter
			axi_write(mem_pkg::count_offset, $urandom, 4'hf, mem_pkg::resp_okay);
			axi_read(mem_pkg::count_offset, count_model, mem_pkg::resp_okay);
		end

		test_name = "bad offset";
		axi_read(12'h008, 32'h0, mem_pkg::resp_slverr);
		axi_write(12'h008, 32'hffff_ffff, 4'hf, mem_pkg::resp_slverr);
		axi_read(mem_pkg::ctrl_offset, cfg_model.raw, mem_pkg::resp_okay);
		axi_read(mem_pkg::count_offset, count_model, mem_pkg::resp_okay);

		$display("checks: %0d, errors: %0d, assertion failures: %0d", checks, errors,
			UUT.u_assertions.fails);
		if (errors == 0 && UUT.u_assertions.fails == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

`default_nettype wire

// ==== all.f ====
common/mem_pkg.sv
hdl/bank_decoder.sv
sram_bridge/sram_bridge.sv
sram_bridge/bridge_config_regs.sv
hdl/chipset_memory.sv
tb/chipset_memory_assertions.sv
tb/chipset_memory_tb.sv

// ==== Makefile ====
# Verilator flow for the memory path
# make lint | make sim | make clean

VERILATOR ?= verilator
TOP       ?= chipset_memory_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only -Wall --timing

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# the log decides, a missing closing line counts as a failure
sim: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Errors found" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "No errors" $(LOG); then echo "simulation did not complete"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
